//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the read-only cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/ro_cache_sim

verilator --binary --timing -f verilog.f --top-module ro_cache_tb -o ro_cache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation finished cleanly"
exit 0

//--- verif/ro_cache_tb.sv
/*
 * Read-only cache testbench.
 * Drives reads through the slave port of the cache, answers the memory
 * port with a model of fixed data and a latency, and compares every
 * response and the number of memory reads with reference values.
 */

`timescale 1ns/1ps
`default_nettype none

module ro_cache_tb
  import axi_lite_pkg::*;
  import ro_cache_pkg::*;
();

  localparam int unsigned LINES       = 16;
  localparam int unsigned INDEX_BITS  = $clog2(LINES);
  localparam int unsigned STREAM_LEN  = 200;
  localparam int unsigned TOTAL_READS = 25 + STREAM_LEN;
  localparam int unsigned WATCHDOG_NS = (TOTAL_READS * 12 + 200) * 4;
  localparam addr_t       XOR_MASK    = 32'hA5A5_0F0F;

  logic     clk_i;
  logic     rst_i;
  logic     enable_i;
  region_t  region_i;
  logic     flush_valid_i;
  logic     flush_ready_o;
  logic     s_ar_valid_i;
  ar_chan_t s_ar_i;
  logic     s_ar_ready_o;
  logic     s_r_valid_o;
  r_chan_t  s_r_o;
  logic     s_r_ready_i;
  logic     m_ar_valid_o;
  ar_chan_t m_ar_o;
  logic     m_ar_ready_i;
  logic     m_r_valid_i;
  r_chan_t  m_r_i;
  logic     m_r_ready_o;

  string       test_name;
  int unsigned errors;
  int unsigned test_errors;
  int unsigned tests_run;
  int unsigned issued;
  int unsigned resp_count;
  int unsigned mem_reads;
  int unsigned reads_before;
  int unsigned cycle;
  int unsigned rise_cycle;
  bit          r_valid_prev;
  bit          drop_ready;
  addr_t       exp_q [$];
  addr_t       exp_addr;

  ro_cache_top #(
    .LINE_COUNT (LINES)
  ) dut0 (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .enable_i      (enable_i),
    .region_i      (region_i),
    .flush_valid_i (flush_valid_i),
    .flush_ready_o (flush_ready_o),
    .s_ar_valid_i  (s_ar_valid_i),
    .s_ar_i        (s_ar_i),
    .s_ar_ready_o  (s_ar_ready_o),
    .s_r_valid_o   (s_r_valid_o),
    .s_r_o         (s_r_o),
    .s_r_ready_i   (s_r_ready_i),
    .m_ar_valid_o  (m_ar_valid_o),
    .m_ar_o        (m_ar_o),
    .m_ar_ready_i  (m_ar_ready_i),
    .m_r_valid_i   (m_r_valid_i),
    .m_r_i         (m_r_i),
    .m_r_ready_o   (m_r_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic r_chan_t expected_r(input addr_t addr);
    r_chan_t r;
    r.data = addr ^ XOR_MASK;
    r.resp = (addr >= 32'h0000_F000 && addr <= 32'h0000_F0FF) ? SLVERR : OKAY;
    return r;
  endfunction

  function automatic bit in_region(input addr_t addr);
    return enable_i && addr >= region_i.start_addr && addr < region_i.end_addr;
  endfunction

  function automatic int unsigned line_index(input addr_t addr);
    return (addr >> WORD_ALIGN) & (LINES - 1);
  endfunction

  function automatic addr_t line_tag(input addr_t addr);
    return addr >> (WORD_ALIGN + INDEX_BITS);
  endfunction

  // Words 0..31 share 16 lines, then an error block, then bypass space
  function automatic addr_t pool_addr(input int unsigned k);
    if (k < 32) begin
      return k * 4;
    end else if (k < 48) begin
      return 32'h0000_F0C0 + (k - 32) * 4;
    end
    return 32'h0002_0000 + (k - 48) * 4;
  endfunction

  // A lookup may pass the fill of the read just ahead of it
  function automatic bit shares_line(input addr_t prev, input addr_t cur);
    return prev < 32'h80 && cur < 32'h80 && line_index(prev) == line_index(cur);
  endfunction

  // --------------------
  // Checks
  // --------------------
  task automatic check_r(input string what, input r_chan_t exp, input r_chan_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s: expected data %h resp %s, actual data %h resp %s",
               test_name, what, exp.data, exp.resp.name(), act.data, act.resp.name());
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_count(input string what, input int unsigned exp,
                             input int unsigned act);
    if (exp != act) begin
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_prot(input string what, input logic [2:0] exp,
                            input logic [2:0] act);
    if (exp !== act) begin
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  // Pairs each response with the oldest outstanding read
  always @(negedge clk_i) begin
    if (s_r_valid_o && !r_valid_prev) begin
      rise_cycle = cycle;
    end
    r_valid_prev = s_r_valid_o;
    if (s_r_valid_o && s_r_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Response arrived with no read outstanding in test %s", test_name);
        errors++;
        test_errors++;
      end else begin
        exp_addr = exp_q.pop_front();
        check_r($sformatf("read %h", exp_addr), expected_r(exp_addr), s_r_o);
      end
      resp_count++;
    end
  end

  // Memory with a random latency of 0 to 5 cycles
  initial begin
    addr_t       addr;
    int unsigned lat;
    m_ar_ready_i = 1'b1;
    m_r_valid_i  = 1'b0;
    m_r_i        = '0;
    forever begin
      @(negedge clk_i);
      if (m_ar_valid_o && m_ar_ready_i) begin
        addr = m_ar_o.addr;
        check_prot("memory AR prot", 3'b000, m_ar_o.prot);
        mem_reads++;
        lat = $urandom % 6;
        @(posedge clk_i);
        repeat (lat) @(posedge clk_i);
        #1;
        m_r_valid_i = 1'b1;
        m_r_i.data  = addr ^ XOR_MASK;
        m_r_i.resp  = (addr[31:8] == 24'h0000F0) ? SLVERR : OKAY;
        @(negedge clk_i);
        while (!m_r_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        m_r_valid_i = 1'b0;
      end
    end
  end

  initial begin
    s_r_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      s_r_ready_i = drop_ready ? (($urandom % 4) != 0) : 1'b1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d of %0d responses back",
             WATCHDOG_NS, resp_count, issued);
    $display("ERRORS FOUND");
    $finish;
  end

  // --------------------
  // Stimulus helpers
  // --------------------
  task automatic issue_read(input addr_t addr, output int unsigned ar_cyc);
    s_ar_valid_i = 1'b1;
    s_ar_i.addr  = addr;
    s_ar_i.prot  = 3'b000;
    exp_q.push_back(addr);
    issued++;
    @(negedge clk_i);
    while (!s_ar_ready_o) @(negedge clk_i);
    ar_cyc = cycle;
    @(posedge clk_i);
    #1;
    s_ar_valid_i = 1'b0;
  endtask

  task automatic wait_responses();
    while (resp_count != issued) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic flush_cache();
    flush_valid_i = 1'b1;
    @(negedge clk_i);
    while (!flush_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    flush_valid_i = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    test_errors  = 0;
    reads_before = mem_reads;
  endtask

  task automatic end_test(input int unsigned exp_fetches);
    wait_responses();
    check_count("memory reads", exp_fetches, mem_reads - reads_before);
    tests_run++;
    $display("Test %0d %s finished with %0d mismatches", tests_run, test_name, test_errors);
  endtask

  initial begin
    addr_t       stream [STREAM_LEN];
    addr_t       pick_addr;
    r_chan_t     fill_rsp;
    int unsigned ar_cyc;
    int unsigned fetches;
    int unsigned idx;
    logic        model_valid [LINES];
    addr_t       model_tag [LINES];

    void'($urandom(74281));
    rst_i         = 1'b1;
    enable_i      = 1'b1;
    region_i      = '{start_addr: 32'h0000_0000, end_addr: 32'h0001_0000};
    flush_valid_i = 1'b0;
    s_ar_valid_i  = 1'b0;
    s_ar_i        = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Second pass rereads after the first pass has settled
    start_test("bypass");
    region_i = '{start_addr: 32'h0000_1000, end_addr: 32'h0000_2000};
    issue_read(32'h0000_0100, ar_cyc);
    issue_read(32'h0000_3000, ar_cyc);
    issue_read(32'h0000_2000, ar_cyc);
    issue_read(32'h0000_0FFC, ar_cyc);
    issue_read(32'h8000_0000, ar_cyc);
    wait_responses();
    issue_read(32'h0000_3000, ar_cyc);
    issue_read(32'h0000_2000, ar_cyc);
    issue_read(32'h0000_0FFC, ar_cyc);
    end_test(8);
    region_i = '{start_addr: 32'h0000_0000, end_addr: 32'h0001_0000};

    // 0x40 and 0x80 land on the same line
    start_test("hit_evict");
    issue_read(32'h0000_0040, ar_cyc);
    wait_responses();
    issue_read(32'h0000_0040, ar_cyc);
    wait_responses();
    check_count("hit latency", 3, rise_cycle - ar_cyc);
    issue_read(32'h0000_0080, ar_cyc);
    wait_responses();
    issue_read(32'h0000_0040, ar_cyc);
    end_test(3);

    // 0x40 is still held in the store from the previous test
    start_test("enable_off");
    enable_i = 1'b0;
    repeat (3) issue_read(32'h0000_0040, ar_cyc);
    end_test(3);
    enable_i = 1'b1;

    start_test("flush");
    issue_read(32'h0000_0100, ar_cyc);
    issue_read(32'h0000_0104, ar_cyc);
    wait_responses();
    issue_read(32'h0000_0100, ar_cyc);
    issue_read(32'h0000_0104, ar_cyc);
    wait_responses();
    flush_cache();
    issue_read(32'h0000_0100, ar_cyc);
    issue_read(32'h0000_0104, ar_cyc);
    end_test(4);

    start_test("errors");
    issue_read(32'h0000_F010, ar_cyc);
    wait_responses();
    issue_read(32'h0000_F010, ar_cyc);
    issue_read(32'h0000_F100, ar_cyc);
    wait_responses();
    issue_read(32'h0000_F100, ar_cyc);
    end_test(3);

    // Random stream with expected fetches from a model of the lines
    start_test("stream");
    flush_cache();
    for (int i = 0; i < LINES; i++) begin
      model_valid[i] = 1'b0;
    end
    fetches = 0;
    for (int i = 0; i < STREAM_LEN; i++) begin
      pick_addr = pool_addr($urandom % 64);
      while (i > 0 && shares_line(stream[i-1], pick_addr)) begin
        pick_addr = pool_addr($urandom % 64);
      end
      stream[i] = pick_addr;
      idx       = line_index(pick_addr);
      if (!in_region(pick_addr) || !model_valid[idx] ||
          model_tag[idx] != line_tag(pick_addr)) begin
        fetches++;
        fill_rsp = expected_r(pick_addr);
        if (in_region(pick_addr) && fill_rsp.resp == OKAY) begin
          model_valid[idx] = 1'b1;
          model_tag[idx]   = line_tag(pick_addr);
        end
      end
    end
    drop_ready = 1'b1;
    for (int i = 0; i < STREAM_LEN; i++) begin
      issue_read(stream[i], ar_cyc);
      if (($urandom % 3) == 0) begin
        @(posedge clk_i);
        #1;
      end
    end
    end_test(fetches);
    drop_ready = 1'b0;

    $display("Tests run %0d, responses checked %0d, mismatches %0d",
             tests_run, resp_count, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
verilog/axi_lite_pkg.sv
verilog/ro_cache_pkg.sv
verilog/ro_cache_ar_steer.sv
verilog/ro_cache_line_store.sv
verilog/ro_cache_refill.sv
verilog/ro_cache_top.sv
verif/ro_cache_tb.sv

//--- verilog/axi_lite_pkg.sv
/*
 * AXI4-Lite read channel definitions.
 * Address and data widths, the AR and R payload structs and the
 * response code shared by the slave and memory ports.
 */

`default_nettype none

package axi_lite_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } ar_chan_t;

  typedef struct packed {
    data_t     data;
    axi_resp_e resp;
  } r_chan_t;

endpackage

`default_nettype wire

//--- verilog/ro_cache_ar_steer.sv
/*
 * Read-only cache AR steer stage.
 * Accepts reads from the slave port and decides whether each one is
 * cacheable. The request is held in one register until the line store
 * takes it as a lookup.
 */

`timescale 1ns/1ps
`default_nettype none

module ro_cache_ar_steer
  import axi_lite_pkg::*;
  import ro_cache_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        s_ar_valid_i,
  input  wire ar_chan_t    s_ar_i,
  output logic             s_ar_ready_o,
  input  wire logic        enable_i,
  input  wire region_t     region_i,
  output logic             lookup_valid_o,
  output lookup_req_t      lookup_req_o,
  input  wire logic        lookup_ready_i
);

  logic        req_valid_q;
  lookup_req_t req_q;
  logic        in_region;
  logic        ar_hs;

  // Region is start inclusive, end exclusive
  assign in_region = (s_ar_i.addr >= region_i.start_addr) &&
                     (s_ar_i.addr < region_i.end_addr);

  // Free slot, or the held request leaves this cycle
  assign s_ar_ready_o = !req_valid_q || lookup_ready_i;
  assign ar_hs        = s_ar_valid_i && s_ar_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      req_valid_q <= 1'b0;
    end else if (ar_hs) begin
      req_valid_q <= 1'b1;
    end else if (lookup_ready_i) begin
      req_valid_q <= 1'b0;
    end
  end

  // Cacheability is fixed at the AR handshake
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      req_q.addr      <= s_ar_i.addr;
      req_q.cacheable <= enable_i && in_region;
    end
  end

  assign lookup_valid_o = req_valid_q;
  assign lookup_req_o   = req_q;

endmodule

`default_nettype wire

//--- verilog/ro_cache_line_store.sv
/*
 * Read-only cache line store.
 * Direct-mapped tag, data and valid arrays with one word per line.
 * Lookups are registered and answer one cycle after acceptance. Lines
 * are written by the refill unit and the flush handshake clears all
 * valid bits.
 */

`timescale 1ns/1ps
`default_nettype none

module ro_cache_line_store
  import axi_lite_pkg::*;
  import ro_cache_pkg::*;
#(
  parameter int unsigned LINE_COUNT = 16
) (
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        lookup_valid_i,
  input  wire lookup_req_t lookup_req_i,
  output logic             lookup_ready_o,
  output logic             result_valid_o,
  output lookup_rsp_t      result_o,
  input  wire logic        result_ready_i,
  input  wire logic        line_write_valid_i,
  input  wire line_write_t line_write_i,
  input  wire logic        flush_valid_i,
  output logic             flush_ready_o
);

  localparam int unsigned INDEX_WIDTH = $clog2(LINE_COUNT);
  localparam int unsigned TAG_WIDTH   = ADDR_WIDTH - WORD_ALIGN - INDEX_WIDTH;

  // --------------------
  // Storage
  // --------------------
  data_t                  data_q [LINE_COUNT];
  logic [TAG_WIDTH-1:0]   tag_q  [LINE_COUNT];
  logic [LINE_COUNT-1:0]  valid_q;

  logic                   result_valid_q;
  lookup_rsp_t            result_q;

  logic [INDEX_WIDTH-1:0] lookup_index;
  logic [TAG_WIDTH-1:0]   lookup_tag;
  logic [INDEX_WIDTH-1:0] write_index;
  logic [TAG_WIDTH-1:0]   write_tag;
  logic                   lookup_hs;
  logic                   flush_hs;

  assign lookup_index = lookup_req_i.addr[WORD_ALIGN +: INDEX_WIDTH];
  assign lookup_tag   = lookup_req_i.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign write_index  = line_write_i.addr[WORD_ALIGN +: INDEX_WIDTH];
  assign write_tag    = line_write_i.addr[ADDR_WIDTH-1 -: TAG_WIDTH];

  // Flush only on an empty, quiet stage
  assign flush_ready_o  = !result_valid_q && !lookup_valid_i;
  assign flush_hs       = flush_valid_i && flush_ready_o;
  assign lookup_ready_o = (!result_valid_q || result_ready_i) && !flush_hs;
  assign lookup_hs      = lookup_valid_i && lookup_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      if (line_write_valid_i) begin
        valid_q[write_index] <= 1'b1;
      end
      // flush overrides a write in the same cycle
      if (flush_hs) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (line_write_valid_i) begin
      data_q[write_index] <= line_write_i.data;
      tag_q[write_index]  <= write_tag;
    end
  end

  // --------------------
  // Lookup result
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_valid_q <= 1'b0;
    end else if (lookup_hs) begin
      result_valid_q <= 1'b1;
    end else if (result_ready_i) begin
      result_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_hs) begin
      result_q.addr      <= lookup_req_i.addr;
      result_q.cacheable <= lookup_req_i.cacheable;
      result_q.hit       <= valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
      result_q.data      <= data_q[lookup_index];
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_o       = result_q;

endmodule

`default_nettype wire

//--- verilog/ro_cache_pkg.sv
/*
 * Read-only cache internal definitions.
 * Region bounds, the lookup request and result carried between the
 * pipeline stages, the line write and the refill FSM states.
 */

`default_nettype none

package ro_cache_pkg;

  import axi_lite_pkg::*;

  // Byte offset bits below the word
  localparam int unsigned WORD_ALIGN = 2;

  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } region_t;

  typedef struct packed {
    addr_t addr;
    logic  cacheable;
  } lookup_req_t;

  typedef struct packed {
    addr_t addr;
    logic  cacheable;
    logic  hit;
    data_t data;
  } lookup_rsp_t;

  typedef struct packed {
    addr_t addr;
    data_t data;
  } line_write_t;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    RESPOND
  } refill_state_e;

endpackage

`default_nettype wire

//--- verilog/ro_cache_refill.sv
/*
 * Read-only cache refill unit.
 * Returns stored data on a hit. Misses and bypass reads go out as a
 * single memory read, and OKAY data of cacheable reads is written back
 * into the line store. One read is handled at a time.
 */

`timescale 1ns/1ps
`default_nettype none

module ro_cache_refill
  import axi_lite_pkg::*;
  import ro_cache_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        result_valid_i,
  input  wire lookup_rsp_t result_i,
  output logic             result_ready_o,
  output logic             m_ar_valid_o,
  output ar_chan_t         m_ar_o,
  input  wire logic        m_ar_ready_i,
  input  wire logic        m_r_valid_i,
  input  wire r_chan_t     m_r_i,
  output logic             m_r_ready_o,
  output logic             s_r_valid_o,
  output r_chan_t          s_r_o,
  input  wire logic        s_r_ready_i,
  output logic             line_write_valid_o,
  output line_write_t      line_write_o
);

  refill_state_e state_q;
  refill_state_e state_d;
  logic          m_ar_valid_q;
  addr_t         addr_q;
  logic          cacheable_q;
  r_chan_t       s_r_q;

  logic          result_hs;
  logic          is_hit;
  logic          m_ar_hs;
  logic          m_r_hs;

  assign result_ready_o = (state_q == IDLE);
  assign result_hs      = result_valid_i && result_ready_o;
  assign is_hit         = result_i.cacheable && result_i.hit;
  assign m_ar_hs        = m_ar_valid_o && m_ar_ready_i;
  assign m_r_ready_o    = (state_q == FETCH);
  assign m_r_hs         = m_r_valid_i && m_r_ready_o;

  // --------------------
  // State machine
  // --------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (result_hs) begin
          state_d = is_hit ? RESPOND : FETCH;
        end
      end
      FETCH: begin
        if (m_r_hs) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        if (s_r_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= IDLE;
      m_ar_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // AR goes out once per miss or bypass
      if (result_hs && !is_hit) begin
        m_ar_valid_q <= 1'b1;
      end else if (m_ar_hs) begin
        m_ar_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (result_hs) begin
      addr_q      <= result_i.addr;
      cacheable_q <= result_i.cacheable;
      s_r_q.data  <= result_i.data;
      s_r_q.resp  <= OKAY;
    end else if (m_r_hs) begin
      s_r_q <= m_r_i;
    end
  end

  assign m_ar_valid_o = m_ar_valid_q;
  assign m_ar_o.addr  = addr_q;
  assign m_ar_o.prot  = 3'b000;

  assign s_r_valid_o = (state_q == RESPOND);
  assign s_r_o       = s_r_q;

  // Error responses never reach the store
  assign line_write_valid_o = m_r_hs && cacheable_q && (m_r_i.resp == OKAY);
  assign line_write_o.addr  = addr_q;
  assign line_write_o.data  = m_r_i.data;

endmodule

`default_nettype wire

//--- verilog/ro_cache_top.sv
/*
 * Read-only cache top level.
 * Connects the AR steer stage, the line store and the refill unit
 * between an AXI4-Lite read slave port and a memory read port.
 */

`timescale 1ns/1ps
`default_nettype none

module ro_cache_top
  import axi_lite_pkg::*;
  import ro_cache_pkg::*;
#(
  parameter int unsigned LINE_COUNT = 16
) (
  input  wire logic     clk_i,
  input  wire logic     rst_i,
  input  wire logic     enable_i,
  input  wire region_t  region_i,
  input  wire logic     flush_valid_i,
  output logic          flush_ready_o,
  // Slave read port
  input  wire logic     s_ar_valid_i,
  input  wire ar_chan_t s_ar_i,
  output logic          s_ar_ready_o,
  output logic          s_r_valid_o,
  output r_chan_t       s_r_o,
  input  wire logic     s_r_ready_i,
  // Memory read port
  output logic          m_ar_valid_o,
  output ar_chan_t      m_ar_o,
  input  wire logic     m_ar_ready_i,
  input  wire logic     m_r_valid_i,
  input  wire r_chan_t  m_r_i,
  output logic          m_r_ready_o
);

  logic        lookup_valid;
  lookup_req_t lookup_req;
  logic        lookup_ready;
  logic        result_valid;
  lookup_rsp_t result;
  logic        result_ready;
  logic        line_write_valid;
  line_write_t line_write;

  ro_cache_ar_steer u_steer (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .s_ar_valid_i   (s_ar_valid_i),
    .s_ar_i         (s_ar_i),
    .s_ar_ready_o   (s_ar_ready_o),
    .enable_i       (enable_i),
    .region_i       (region_i),
    .lookup_valid_o (lookup_valid),
    .lookup_req_o   (lookup_req),
    .lookup_ready_i (lookup_ready)
  );

  ro_cache_line_store #(
    .LINE_COUNT (LINE_COUNT)
  ) u_store (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .lookup_valid_i     (lookup_valid),
    .lookup_req_i       (lookup_req),
    .lookup_ready_o     (lookup_ready),
    .result_valid_o     (result_valid),
    .result_o           (result),
    .result_ready_i     (result_ready),
    .line_write_valid_i (line_write_valid),
    .line_write_i       (line_write),
    .flush_valid_i      (flush_valid_i),
    .flush_ready_o      (flush_ready_o)
  );

  ro_cache_refill u_refill (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .result_valid_i     (result_valid),
    .result_i           (result),
    .result_ready_o     (result_ready),
    .m_ar_valid_o       (m_ar_valid_o),
    .m_ar_o             (m_ar_o),
    .m_ar_ready_i       (m_ar_ready_i),
    .m_r_valid_i        (m_r_valid_i),
    .m_r_i              (m_r_i),
    .m_r_ready_o        (m_r_ready_o),
    .s_r_valid_o        (s_r_valid_o),
    .s_r_o              (s_r_o),
    .s_r_ready_i        (s_r_ready_i),
    .line_write_valid_o (line_write_valid),
    .line_write_o       (line_write)
  );

endmodule

`default_nettype wire
